// ==== src/cariboulite_pkg.sv ====
`default_nettype none

package cariboulite_pkg;

  // ==============================
  // Sample path
  // ==============================
  localparam int SAMPLE_W        = 32;  // One raw I/Q frame
  localparam int PAIRS_PER_FRAME = 16;  // 2-bit pairs per frame
  localparam int PAIRS_PER_WORD  = 8;   // Pairs in the I word, same for Q

  localparam logic [1:0] SYNC_I = 2'b10;  // First pair of the I word
  localparam logic [1:0] SYNC_Q = 2'b01;  // First pair of the Q word

  localparam int FIFO_AW = 4;  // 16 entries

  // ==============================
  // Register access
  // ==============================
  localparam int BYTE_W = 8;
  localparam int IOC_W  = 5;

  localparam logic [BYTE_W-1:0] VERSION       = 8'h01;
  localparam logic [BYTE_W-1:0] RESERVED_READ = 8'hA5;  // Reserved module answer

  // System module register map
  localparam logic [IOC_W-1:0] REG_VERSION  = 5'd0;
  localparam logic [IOC_W-1:0] REG_SCRATCH  = 5'd1;
  localparam logic [IOC_W-1:0] REG_RX_CTRL  = 5'd2;  // Bit 0 is RX enable
  localparam logic [IOC_W-1:0] REG_DROP_CNT = 5'd3;  // Read only

  // Module id, bits 6:5 of the command byte
  typedef enum logic [1:0] {
    MOD_SYS      = 2'd0,
    MOD_IO       = 2'd1,
    MOD_SMI      = 2'd2,
    MOD_RESERVED = 2'd3
  } module_id_e;

  typedef enum logic [1:0] {
    IDLE,    // Hunting for SYNC_I
    I_WORD,
    Q_WORD
  } deframe_state_e;

  typedef enum logic [1:0] {
    EMPTY,      // Nothing held, pop when FIFO has data
    WAIT_DATA,  // FIFO read in flight
    BYTES       // Handing bytes to the host
  } smi_state_e;

endpackage

`default_nettype wire

// ==== src/reg_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Command path from the SPI slave into the register block
interface reg_bus_if;
  logic [cariboulite_pkg::IOC_W-1:0]  ioc;         // Register address
  cariboulite_pkg::module_id_e        module_sel;  // Target module
  logic [cariboulite_pkg::BYTE_W-1:0] wdata;       // Valid with load
  logic                               load;        // Write strobe, one cycle
  logic                               fetch;       // Read strobe, one cycle
  logic [cariboulite_pkg::BYTE_W-1:0] rdata;       // Valid from cycle after fetch

  modport master (
    output ioc,
    output module_sel,
    output wdata,
    output load,
    output fetch,
    input  rdata
  );

  modport slave (
    input  ioc,
    input  module_sel,
    input  wdata,
    input  load,
    input  fetch,
    output rdata
  );
endinterface

`default_nettype wire

// ==== src/spi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
  input  logic      i_glob_clock,
  input  logic      i_rst_b,
  input  logic      i_sck,
  input  logic      i_mosi,
  input  logic      i_ss,
  output logic      o_miso,
  reg_bus_if.master bus
);

  logic [1:0] sck_sync;   // Two-stage synchronizers
  logic [1:0] mosi_sync;
  logic [1:0] ss_sync;
  logic       sck_prev;   // For edge detect
  logic       sck_rise;
  logic       sck_fall;
  logic [4:0] bit_cnt;    // Bits seen in this frame, 0 to 16
  logic       is_write;   // Write flag of current command
  logic       cmd_done;   // Command byte just completed
  logic [cariboulite_pkg::BYTE_W-1:0] rx_shift;
  logic [cariboulite_pkg::BYTE_W-1:0] rx_byte;
  logic [cariboulite_pkg::BYTE_W-1:0] tx_shift;

  // ==============================
  // Input sync and edge detect
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      sck_sync  <= 2'b00;
      mosi_sync <= 2'b00;
      ss_sync   <= 2'b11;  // Deselected
      sck_prev  <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[0], i_sck};
      mosi_sync <= {mosi_sync[0], i_mosi};
      ss_sync   <= {ss_sync[0], i_ss};
      sck_prev  <= sck_sync[1];
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_prev;
  assign sck_fall = ~sck_sync[1] & sck_prev;
  assign rx_byte  = {rx_shift[cariboulite_pkg::BYTE_W-2:0], mosi_sync[1]};  // Byte incl. this bit

  // ==============================
  // Frame control and strobes
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      bit_cnt   <= '0;
      is_write  <= 1'b0;
      cmd_done  <= 1'b0;
      bus.fetch <= 1'b0;
      bus.load  <= 1'b0;
      o_miso    <= 1'b0;
    end else begin
      cmd_done  <= 1'b0;
      bus.load  <= 1'b0;
      bus.fetch <= cmd_done & ~is_write;  // Second clock after 8th rise
      if (ss_sync[1]) begin
        bit_cnt <= '0;  // Frame ends with ss high
        o_miso  <= 1'b0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 5'd7) begin
            is_write <= rx_byte[7];  // MSB of command
            cmd_done <= 1'b1;
          end
          if (bit_cnt == 5'd15 && is_write) begin
            bus.load <= 1'b1;
          end
        end
        // Read data leaves after each falling sck of byte two
        if (sck_fall && !is_write) begin
          if (bit_cnt == 5'd8) begin
            o_miso <= bus.rdata[7];
          end else if (bit_cnt > 5'd8 && bit_cnt < 5'd16) begin
            o_miso <= tx_shift[7];
          end
        end
      end
    end
  end

  // Shift registers and command fields
  always_ff @(posedge i_glob_clock) begin
    if (sck_rise) begin
      rx_shift <= rx_byte;
      if (bit_cnt == 5'd7) begin
        bus.module_sel <= cariboulite_pkg::module_id_e'(rx_byte[6:5]);
        bus.ioc        <= rx_byte[4:0];
      end
      if (bit_cnt == 5'd15) begin
        bus.wdata <= rx_byte;
      end
    end
    if (sck_fall) begin
      if (bit_cnt == 5'd8) begin
        tx_shift <= {bus.rdata[cariboulite_pkg::BYTE_W-2:0], 1'b0};  // Rest after MSB
      end else begin
        tx_shift <= {tx_shift[cariboulite_pkg::BYTE_W-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  logic     i_glob_clock,
  input  logic     i_rst_b,
  reg_bus_if.slave bus,
  input  logic     i_drop,
  output logic     o_rx_en
);

  logic [cariboulite_pkg::BYTE_W-1:0] scratch;
  logic [cariboulite_pkg::BYTE_W-1:0] drop_cnt;   // Saturates at 255
  logic [cariboulite_pkg::BYTE_W-1:0] sys_rdata;  // System module readback

  // ==============================
  // Writes and drop counter
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      scratch  <= '0;
      o_rx_en  <= 1'b0;
      drop_cnt <= '0;
    end else begin
      if (bus.load && bus.module_sel == cariboulite_pkg::MOD_SYS) begin
        case (bus.ioc)
          cariboulite_pkg::REG_SCRATCH: scratch <= bus.wdata;
          cariboulite_pkg::REG_RX_CTRL: o_rx_en <= bus.wdata[0];
          default: ;  // Version and drop count are read only
        endcase
      end
      if (i_drop && drop_cnt != '1) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
    end
  end

  // System register map
  always_comb begin
    case (bus.ioc)
      cariboulite_pkg::REG_VERSION:  sys_rdata = cariboulite_pkg::VERSION;
      cariboulite_pkg::REG_SCRATCH:  sys_rdata = scratch;
      cariboulite_pkg::REG_RX_CTRL:  sys_rdata = {7'b0, o_rx_en};
      cariboulite_pkg::REG_DROP_CNT: sys_rdata = drop_cnt;
      default:                       sys_rdata = '0;
    endcase
  end

  // Readback per module, held until the next fetch
  always_ff @(posedge i_glob_clock) begin
    if (bus.fetch) begin
      case (bus.module_sel)
        cariboulite_pkg::MOD_SYS:      bus.rdata <= sys_rdata;
        cariboulite_pkg::MOD_RESERVED: bus.rdata <= cariboulite_pkg::RESERVED_READ;
        default:                       bus.rdata <= '0;  // IO and SMI not present
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/iq_deframer.sv ====
`timescale 1ns/1ps
`default_nettype none

module iq_deframer (
  input  logic                                 i_glob_clock,
  input  logic                                 i_rst_b,
  input  logic [1:0]                           i_pair,    // One pair per clock
  input  logic                                 i_rx_en,
  output logic                                 o_push,    // One cycle, frame valid
  output logic [cariboulite_pkg::SAMPLE_W-1:0] o_frame
);

  cariboulite_pkg::deframe_state_e state;

  logic [$clog2(cariboulite_pkg::PAIRS_PER_FRAME)-1:0] pair_cnt;  // Pairs taken so far
  logic [cariboulite_pkg::SAMPLE_W-1:0]                frame_sr;  // First pair ends on top

  // ==============================
  // Sync search and frame FSM
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      state    <= cariboulite_pkg::IDLE;
      pair_cnt <= '0;
      o_push   <= 1'b0;
    end else begin
      o_push <= 1'b0;
      case (state)
        cariboulite_pkg::IDLE: begin
          if (i_pair == cariboulite_pkg::SYNC_I) begin
            state    <= cariboulite_pkg::I_WORD;
            pair_cnt <= 1'b1;  // Sync pair already counted
          end
        end
        cariboulite_pkg::I_WORD: begin
          pair_cnt <= pair_cnt + 1'b1;
          if (pair_cnt == cariboulite_pkg::PAIRS_PER_WORD - 1) begin
            state <= cariboulite_pkg::Q_WORD;
          end
        end
        cariboulite_pkg::Q_WORD: begin
          pair_cnt <= pair_cnt + 1'b1;
          if (pair_cnt == cariboulite_pkg::PAIRS_PER_WORD &&
              i_pair != cariboulite_pkg::SYNC_Q) begin
            state <= cariboulite_pkg::IDLE;  // Bad Q sync, abandon frame
          end else if (pair_cnt == cariboulite_pkg::PAIRS_PER_FRAME - 1) begin
            state  <= cariboulite_pkg::IDLE;  // Next frame may follow at once
            o_push <= i_rx_en;
          end
        end
        default: state <= cariboulite_pkg::IDLE;
      endcase
    end
  end

  // Pair shifter, only moves while a frame is being collected
  always_ff @(posedge i_glob_clock) begin
    if (state != cariboulite_pkg::IDLE || i_pair == cariboulite_pkg::SYNC_I) begin
      frame_sr <= {frame_sr[cariboulite_pkg::SAMPLE_W-3:0], i_pair};
    end
  end

  assign o_frame = frame_sr;  // Complete during the push cycle

endmodule

`default_nettype wire

// ==== src/sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
  input  logic                                 i_glob_clock,
  input  logic                                 i_rst_b,
  input  logic                                 i_channel,   // 0 selects 09, 1 selects 24
  input  logic                                 i_push_09,
  input  logic [cariboulite_pkg::SAMPLE_W-1:0] i_frame_09,
  input  logic                                 i_push_24,
  input  logic [cariboulite_pkg::SAMPLE_W-1:0] i_frame_24,
  input  logic                                 i_pop,
  output logic [cariboulite_pkg::SAMPLE_W-1:0] o_rdata,     // Valid cycle after pop
  output logic                                 o_empty,
  output logic                                 o_drop       // Push lost to full
);

  logic [cariboulite_pkg::SAMPLE_W-1:0] mem [2**cariboulite_pkg::FIFO_AW];
  logic [cariboulite_pkg::FIFO_AW:0]    wr_ptr;  // Extra bit tells full from empty
  logic [cariboulite_pkg::FIFO_AW:0]    rd_ptr;
  logic                                 push;
  logic [cariboulite_pkg::SAMPLE_W-1:0] wdata;
  logic                                 full;

  // Channel select
  assign push  = i_channel ? i_push_24 : i_push_09;
  assign wdata = i_channel ? i_frame_24 : i_frame_09;

  assign o_empty = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[cariboulite_pkg::FIFO_AW] != rd_ptr[cariboulite_pkg::FIFO_AW]) &&
                   (wr_ptr[cariboulite_pkg::FIFO_AW-1:0] == rd_ptr[cariboulite_pkg::FIFO_AW-1:0]);

  // ==============================
  // Pointers and drop strobe
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      o_drop <= 1'b0;
    end else begin
      o_drop <= push & full;
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop && !o_empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage and registered read
  always_ff @(posedge i_glob_clock) begin
    if (push && !full) begin
      mem[wr_ptr[cariboulite_pkg::FIFO_AW-1:0]] <= wdata;
    end
    if (i_pop && !o_empty) begin
      o_rdata <= mem[rd_ptr[cariboulite_pkg::FIFO_AW-1:0]];
    end
  end

endmodule

`default_nettype wire

// ==== src/smi_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module smi_reader (
  input  logic                                 i_glob_clock,
  input  logic                                 i_rst_b,
  input  logic                                 i_empty,
  input  logic [cariboulite_pkg::SAMPLE_W-1:0] i_rdata,
  input  logic                                 i_smi_soe_se,   // Host read strobe
  output logic                                 o_pop,
  output logic [cariboulite_pkg::BYTE_W-1:0]   o_smi_data,
  output logic                                 o_smi_read_req  // Byte on the bus
);

  cariboulite_pkg::smi_state_e state;

  logic [$clog2(cariboulite_pkg::SAMPLE_W / cariboulite_pkg::BYTE_W)-1:0] byte_idx;
  logic [cariboulite_pkg::SAMPLE_W-1:0] word_sr;  // Current byte sits on top

  assign o_pop      = (state == cariboulite_pkg::EMPTY) && !i_empty;
  assign o_smi_data = word_sr[cariboulite_pkg::SAMPLE_W-1 -: cariboulite_pkg::BYTE_W];

  // ==============================
  // Hand-out FSM
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      state          <= cariboulite_pkg::EMPTY;
      byte_idx       <= '0;
      o_smi_read_req <= 1'b0;
    end else begin
      case (state)
        cariboulite_pkg::EMPTY: begin
          if (!i_empty) begin
            state <= cariboulite_pkg::WAIT_DATA;  // Pop goes out this cycle
          end
        end
        cariboulite_pkg::WAIT_DATA: begin
          state          <= cariboulite_pkg::BYTES;
          byte_idx       <= '0;
          o_smi_read_req <= 1'b1;
        end
        cariboulite_pkg::BYTES: begin
          if (i_smi_soe_se) begin
            byte_idx <= byte_idx + 1'b1;
            if (byte_idx == cariboulite_pkg::SAMPLE_W / cariboulite_pkg::BYTE_W - 1) begin
              state          <= cariboulite_pkg::EMPTY;  // Last byte taken
              o_smi_read_req <= 1'b0;
            end
          end
        end
        default: state <= cariboulite_pkg::EMPTY;
      endcase
    end
  end

  // Word capture then MSB-first byte shift
  always_ff @(posedge i_glob_clock) begin
    if (state == cariboulite_pkg::WAIT_DATA) begin
      word_sr <= i_rdata;
    end else if (state == cariboulite_pkg::BYTES && i_smi_soe_se) begin
      word_sr <= {word_sr[cariboulite_pkg::SAMPLE_W-cariboulite_pkg::BYTE_W-1:0],
                  {cariboulite_pkg::BYTE_W{1'b0}}};
    end
  end

endmodule

`default_nettype wire

// ==== src/cariboulite_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cariboulite_rx_top (
  input  logic                               i_glob_clock,
  input  logic                               i_rst_b,
  input  logic [1:0]                         i_iq_rx_09,     // Captured pair, 900 MHz band
  input  logic [1:0]                         i_iq_rx_24,     // Captured pair, 2.4 GHz band
  input  logic                               i_smi_a3,       // Channel select
  input  logic                               i_smi_soe_se,
  output logic [cariboulite_pkg::BYTE_W-1:0] o_smi_data,
  output logic                               o_smi_read_req,
  input  logic                               i_sck,
  input  logic                               i_mosi,
  input  logic                               i_ss,
  output logic                               o_miso
);

  // ==============================
  // Internal nets
  // ==============================
  logic                                 rx_en;
  logic                                 push_09;
  logic [cariboulite_pkg::SAMPLE_W-1:0] frame_09;
  logic                                 push_24;
  logic [cariboulite_pkg::SAMPLE_W-1:0] frame_24;
  logic [cariboulite_pkg::SAMPLE_W-1:0] fifo_rdata;
  logic                                 fifo_empty;
  logic                                 fifo_pop;
  logic                                 drop;

  reg_bus_if reg_bus0 ();

  // Host register path
  spi_slave spi0 (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_sck        (i_sck),
    .i_mosi       (i_mosi),
    .i_ss         (i_ss),
    .o_miso       (o_miso),
    .bus          (reg_bus0.master)
  );

  ctrl_regs regs0 (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .bus          (reg_bus0.slave),
    .i_drop       (drop),
    .o_rx_en      (rx_en)
  );

  // ==============================
  // Sample path
  // ==============================
  iq_deframer deframer_09 (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_pair       (i_iq_rx_09),
    .i_rx_en      (rx_en),
    .o_push       (push_09),
    .o_frame      (frame_09)
  );

  iq_deframer deframer_24 (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_pair       (~i_iq_rx_24),  // N side on the board
    .i_rx_en      (rx_en),
    .o_push       (push_24),
    .o_frame      (frame_24)
  );

  sample_fifo fifo0 (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_channel    (i_smi_a3),
    .i_push_09    (push_09),
    .i_frame_09   (frame_09),
    .i_push_24    (push_24),
    .i_frame_24   (frame_24),
    .i_pop        (fifo_pop),
    .o_rdata      (fifo_rdata),
    .o_empty      (fifo_empty),
    .o_drop       (drop)
  );

  smi_reader smi0 (
    .i_glob_clock   (i_glob_clock),
    .i_rst_b        (i_rst_b),
    .i_empty        (fifo_empty),
    .i_rdata        (fifo_rdata),
    .i_smi_soe_se   (i_smi_soe_se),
    .o_pop          (fifo_pop),
    .o_smi_data     (o_smi_data),
    .o_smi_read_req (o_smi_read_req)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst_b
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;  // 10 ns period
  end

  // Reset held low over the first 4 rising edges
  initial begin
    o_rst_b = 1'b0;
    repeat (4) @(posedge o_clk);
    #1 o_rst_b = 1'b1;  // Same 1 ns skew as the other inputs
  end

endmodule

`default_nettype wire

// ==== sim/tb_cariboulite_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cariboulite_rx;

  logic                               clk;
  logic                               rst_b;
  logic [1:0]                         iq_rx_09;
  logic [1:0]                         iq_rx_24;   // Driven inverted as on the board
  logic                               smi_a3;
  logic                               smi_soe_se;
  logic [cariboulite_pkg::BYTE_W-1:0] smi_data;
  logic                               smi_read_req;
  logic                               sck;
  logic                               mosi;
  logic                               ss;
  logic                               miso;

  // Parsed test data with one entry per data line
  logic [8*24-1:0] name_q [$];
  logic [8*8-1:0]  op_q   [$];
  logic [31:0]     a_q    [$];
  logic [31:0]     b_q    [$];
  logic [31:0]     c_q    [$];
  logic [31:0]     d_q    [$];
  int              n_lines;
  int              err_cnt;
  int              seed;

  tb_clock_gen clk_gen0 (
    .o_clk   (clk),
    .o_rst_b (rst_b)
  );

  cariboulite_rx_top dut0 (
    .i_glob_clock   (clk),
    .i_rst_b        (rst_b),
    .i_iq_rx_09     (iq_rx_09),
    .i_iq_rx_24     (iq_rx_24),
    .i_smi_a3       (smi_a3),
    .i_smi_soe_se   (smi_soe_se),
    .o_smi_data     (smi_data),
    .o_smi_read_req (smi_read_req),
    .i_sck          (sck),
    .i_mosi         (mosi),
    .i_ss           (ss),
    .o_miso         (miso)
  );

  // ==============================
  // Helpers
  // ==============================
  task automatic step_cycle();
    @(posedge clk);
    #1;  // Inputs move 1 ns after the edge
  endtask

  task automatic report_mismatch(input logic [8*24-1:0] name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    err_cnt++;
    $display("[ERROR] %0s expected %h actual %h", name, exp_v, act_v);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  // Mode 0 and MSB first with each sck level held 8 clocks
  task automatic spi_transfer(input logic wr, input logic [1:0] mod, input logic [4:0] ioc,
                              input logic [7:0] wdata, output logic [7:0] rdata);
    logic [15:0] tx;
    int          i;
    tx    = {wr, mod, ioc, wdata};
    rdata = '0;
    ss    = 1'b0;
    repeat (8) step_cycle();
    for (i = 15; i >= 0; i--) begin
      mosi = tx[i];
      repeat (8) step_cycle();
      if (i < 8) begin
        rdata = {rdata[6:0], miso};  // Settled since the last falling sck
      end
      sck = 1'b1;
      repeat (8) step_cycle();
      sck = 1'b0;
    end
    repeat (8) step_cycle();
    ss   = 1'b1;
    mosi = 1'b0;
    repeat (8) step_cycle();
  endtask

  // Frames with short idle gaps and words counting up by one
  task automatic send_frames(input logic [1:0] mask, input logic [31:0] w09,
                             input logic [31:0] w24, input int count);
    int f;
    int p;
    int gap;
    for (f = 0; f < count; f++) begin
      for (p = 0; p < cariboulite_pkg::PAIRS_PER_FRAME; p++) begin
        iq_rx_09 = mask[0] ? w09[31-2*p -: 2] : 2'b00;
        iq_rx_24 = mask[1] ? ~w24[31-2*p -: 2] : 2'b11;
        step_cycle();
      end
      iq_rx_09 = 2'b00;  // Idle value never matches the I sync
      iq_rx_24 = 2'b11;
      gap      = $urandom % 4;
      repeat (gap) step_cycle();
      w09 = w09 + 1;
      w24 = w24 + 1;
    end
    repeat (4) step_cycle();  // Last push reaches the FIFO
  endtask

  // Reads words over SMI with the MSB byte first
  task automatic read_words(input logic [8*24-1:0] name, input int count,
                            input logic [31:0] first);
    int          w;
    int          b;
    int          wait_cnt;
    logic [31:0] exp_w;
    exp_w = first;
    for (w = 0; w < count; w++) begin
      wait_cnt = 0;
      while (!smi_read_req) begin
        step_cycle();
        wait_cnt++;
        if (wait_cnt > 100) begin
          abort_run("SMI read request never went high");
        end
      end
      for (b = 0; b < 4; b++) begin
        assert (smi_data == exp_w[31-8*b -: 8])
          else report_mismatch(name, exp_w[31-8*b -: 8], smi_data);
        smi_soe_se = 1'b1;  // Single cycle strobe
        step_cycle();
        smi_soe_se = 1'b0;
        step_cycle();
      end
      assert (!smi_read_req) else report_mismatch(name, 0, 1);  // Drops after 4th byte
      exp_w = exp_w + 1;
    end
  endtask

  // No request for 40 cycles with a stray strobe halfway
  task automatic check_no_request(input logic [8*24-1:0] name);
    int c;
    for (c = 0; c < 40; c++) begin
      smi_soe_se = (c == 20);
      step_cycle();
      assert (!smi_read_req) else report_mismatch(name, 0, 1);
    end
    smi_soe_se = 1'b0;
  endtask

  // ==============================
  // Watchdog
  // ==============================
  initial begin
    wait (n_lines > 0);
    repeat (400 * n_lines + 1000) @(posedge clk);
    $display("Run timed out before all data lines were done");
    $display("test failed");
    $fatal(1);
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin : main_seq
    logic [8*128-1:0] line;
    logic [8*24-1:0]  name;
    logic [8*8-1:0]   op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    logic [31:0]      d;
    logic [7:0]       rdata;
    int               fd;
    int               rc;
    int               i;
    iq_rx_09   = 2'b00;
    iq_rx_24   = 2'b11;  // Inverted idle
    smi_a3     = 1'b0;
    smi_soe_se = 1'b0;
    sck        = 1'b0;
    mosi       = 1'b0;
    ss         = 1'b1;
    err_cnt    = 0;
    n_lines    = 0;
    seed       = 32'h988e;
    seed       = $urandom(seed);  // Only picks gaps between frames

    fd = $fopen("sim/cariboulite_rx_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the test data file");
    end
    while (!$feof(fd)) begin
      line = '0;
      rc   = $fgets(line, fd);
      rc   = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, c, d);
      if (rc == 6) begin  // Comment and blank lines fall out here
        name_q.push_back(name);
        op_q.push_back(op);
        a_q.push_back(a);
        b_q.push_back(b);
        c_q.push_back(c);
        d_q.push_back(d);
      end
    end
    $fclose(fd);
    if (name_q.size() == 0) begin
      abort_run("No data lines found in the test data file");
    end
    n_lines = name_q.size();

    wait (rst_b);
    repeat (4) step_cycle();

    for (i = 0; i < n_lines; i++) begin
      name = name_q[i];
      a    = a_q[i];
      b    = b_q[i];
      c    = c_q[i];
      d    = d_q[i];
      case (op_q[i])
        "spi_wr": spi_transfer(1'b1, a[1:0], b[4:0], c[7:0], rdata);
        "spi_rd": begin
          spi_transfer(1'b0, a[1:0], b[4:0], 8'h00, rdata);
          assert (rdata == d[7:0]) else report_mismatch(name, d, rdata);
        end
        "frame":  send_frames(a[1:0], b, c, d);
        "smi_rd": begin
          if (a == 0) begin
            check_no_request(name);
          end else begin
            read_words(name, a, d);
          end
        end
        "chan": begin
          smi_a3 = a[0];  // 0 selects 09 and 1 selects 24
          step_cycle();
        end
        default: abort_run("Unknown operation in the test data");
      endcase
    end

    repeat (4) step_cycle();
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cariboulite_rx.f ====
src/cariboulite_pkg.sv
src/reg_bus_if.sv
src/spi_slave.sv
src/ctrl_regs.sv
src/iq_deframer.sv
src/sample_fifo.sv
src/smi_reader.sv
src/cariboulite_rx_top.sv
sim/tb_clock_gen.sv
sim/tb_cariboulite_rx.sv

// ==== sim/cariboulite_rx_testdata.txt ====
# columns name op a b c d, numbers in hex
# spi_wr mod ioc data, spi_rd mod ioc with the read value in d
# frame mask w09 w24 count, smi_rd count and first word in d, chan in a

ver_rd        spi_rd 0 00 00 01
scratch_wr    spi_wr 0 01 5a 00
scratch_rd    spi_rd 0 01 00 5a
reserved_rd   spi_rd 3 00 00 a5
io_rd         spi_rd 1 01 00 00
smi_wr        spi_wr 2 01 c3 00
scratch_keep  spi_rd 0 01 00 5a
rxen_rd0      spi_rd 0 02 00 00

rx_off_frame  frame  1 9abc5def 0 1
rx_off_none   smi_rd 0 0 0 0
rx_on         spi_wr 0 02 01 00
rxen_rd1      spi_rd 0 02 00 01

both_frame    frame  3 9abc5def a1234567 1
ch0_word      smi_rd 1 0 0 9abc5def
ch0_only      smi_rd 0 0 0 0
chan_24       chan   1 0 0 0
ch1_frame     frame  2 0 b0c07070 1
ch1_word      smi_rd 1 0 0 b0c07070
ch1_only      smi_rd 0 0 0 0
chan_09       chan   0 0 0 0

bad_sync      frame  1 80000000 0 1
good_after    frame  1 95555555 0 1
sync_word     smi_rd 1 0 0 95555555
sync_none     smi_rd 0 0 0 0

drop_rd0      spi_rd 0 03 00 00
ovf_frames    frame  1 80004000 0 15
ovf_drain     smi_rd 11 0 0 80004000
ovf_empty     smi_rd 0 0 0 0
drop_rd       spi_rd 0 03 00 04
drop_ro_wr    spi_wr 0 03 ff 00
drop_ro_rd    spi_rd 0 03 00 04
ver_ro_wr     spi_wr 0 00 7e 00
ver_ro_rd     spi_rd 0 00 00 01

late_frame    frame  1 9abc5def 0 1
late_word     smi_rd 1 0 0 9abc5def
late_none     smi_rd 0 0 0 0
